/* design/cpu_io_pkg.sv */
package cpu_io_pkg;

    // cpu bus widths
    localparam int ADDR_W = 30;
    localparam int DATA_W = 32;

    // word address field that picks the region
    localparam int REGION_HI = 29;
    localparam int REGION_LO = 26;

    typedef enum logic [3:0] {
        REGION_TEXT   = 4'hC,
        REGION_KBD    = 4'hE,
        REGION_LOADER = 4'hF
    } region_e;

    // loader ram, 1024 words
    localparam int LOADER_ADDR_W = 10;

    // text memory write window
    localparam int TEXT_ADDR_W       = 15;
    localparam int TEXT_WEN_CYCLES   = 6;
    localparam int TEXT_STALL_CYCLES = 8;
    // counter must reach TEXT_STALL_CYCLES and hold there
    localparam int TEXT_CNT_W        = 4;

    // keyboard queue
    localparam int KBD_FIFO_DEPTH = 8;
    localparam int KBD_PTR_W      = 3;

    // ps/2 receiver
    typedef enum logic [1:0] {
        PS2_IDLE,
        PS2_SHIFT,
        PS2_CHECK
    } ps2_state_e;

    // start, 8 data, parity, stop
    localparam int PS2_FRAME_BITS = 11;
    localparam int PS2_CNT_W      = 4;

endpackage

/* design/ps2_receiver.sv */
`timescale 1ns/1ps

module ps2_receiver import cpu_io_pkg::*; (
    input  logic       clk_pipeline,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output logic       code_valid,
    output logic [7:0] code
);

    logic [2:0]                clk_sync;
    logic [1:0]                data_sync;
    logic                      clk_fall;
    logic [PS2_FRAME_BITS-1:0] frame;
    logic [PS2_CNT_W-1:0]      bit_cnt;
    logic                      frame_ok;
    ps2_state_e                state;

    ////////////////////
    // synchronizers

    // idle bus is high, so preset to 1 to avoid a false edge
    always_ff @(posedge clk_pipeline) begin
        if (!rst) begin
            clk_sync  <= '1;
            data_sync <= '1;
        end else begin
            clk_sync  <= {clk_sync[1:0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
        end
    end

    // keyboard drives data while clock is high, sample on the fall
    assign clk_fall = clk_sync[2] & ~clk_sync[1];

    ////////////////////
    // frame fsm

    always_ff @(posedge clk_pipeline) begin
        if (!rst) begin
            state   <= PS2_IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                PS2_IDLE: begin
                    if (clk_fall) begin
                        bit_cnt <= PS2_CNT_W'(1);
                        state   <= PS2_SHIFT;
                    end
                end
                PS2_SHIFT: begin
                    if (clk_fall) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == PS2_CNT_W'(PS2_FRAME_BITS - 1)) begin
                            state <= PS2_CHECK;
                        end
                    end
                end
                PS2_CHECK: begin
                    bit_cnt <= '0;
                    state   <= PS2_IDLE;
                end
                default: state <= PS2_IDLE;
            endcase
        end
    end

    // lsb first, so shift in from the top
    always_ff @(posedge clk_pipeline) begin
        if (clk_fall && state != PS2_CHECK) begin
            frame <= {data_sync[1], frame[PS2_FRAME_BITS-1:1]};
        end
    end

    // start low, stop high, odd parity over data and parity bit
    assign frame_ok   = ~frame[0] & frame[PS2_FRAME_BITS-1] & (^frame[PS2_FRAME_BITS-2:1]);
    assign code_valid = (state == PS2_CHECK) && frame_ok;
    assign code       = frame[8:1];

    code_valid_single: assert property (@(posedge clk_pipeline) disable iff (!rst)
        code_valid |=> !code_valid);

endmodule

/* design/scancode_fifo.sv */
`timescale 1ns/1ps

module scancode_fifo import cpu_io_pkg::*; (
    input  logic       clk_pipeline,
    input  logic       rst,
    input  logic       code_valid,
    input  logic [7:0] code,
    input  logic       kb_pop,
    output logic       kb_ready,
    output logic       kb_overflow,
    output logic [7:0] head_code
);

    logic [7:0]           mem [KBD_FIFO_DEPTH];
    logic [KBD_PTR_W-1:0] wr_ptr;
    logic [KBD_PTR_W-1:0] rd_ptr;
    logic [KBD_PTR_W:0]   count;
    logic                 full;
    logic                 push;
    logic                 pop;

    assign full     = (count == (KBD_PTR_W + 1)'(KBD_FIFO_DEPTH));
    assign kb_ready = (count != '0);
    // full queue drops the new code
    assign push     = code_valid && !full;
    assign pop      = kb_pop && kb_ready;

    // storage
    always_ff @(posedge clk_pipeline) begin
        if (push) begin
            mem[wr_ptr] <= code;
        end
    end

    assign head_code = mem[rd_ptr];

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk_pipeline) begin
        if (!rst) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            kb_overflow <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // sticky until reset
            if (code_valid && full) begin
                kb_overflow <= 1'b1;
            end
        end
    end

    count_bound: assert property (@(posedge clk_pipeline) disable iff (!rst)
        count <= (KBD_PTR_W + 1)'(KBD_FIFO_DEPTH));

endmodule

/* design/loader_mem.sv */
`timescale 1ns/1ps

module loader_mem import cpu_io_pkg::*; (
    input  logic                     clk_pipeline,
    input  logic [LOADER_ADDR_W-1:0] data_addr,
    input  logic [LOADER_ADDR_W-1:0] instr_addr,
    input  logic [3:0]               data_wen,
    input  logic [DATA_W-1:0]        wdata,
    output logic [DATA_W-1:0]        data_rdata,
    output logic [DATA_W-1:0]        instr_rdata
);

    logic [DATA_W-1:0] mem [2**LOADER_ADDR_W];

    // data port
    // read returns the old word when the same address is written
    always_ff @(posedge clk_pipeline) begin
        for (int j = 0; j < DATA_W / 8; j++) begin
            if (data_wen[j]) begin
                mem[data_addr][8*j +: 8] <= wdata[8*j +: 8];
            end
        end
        data_rdata <= mem[data_addr];
    end

    // instruction port, read only
    always_ff @(posedge clk_pipeline) begin
        instr_rdata <= mem[instr_addr];
    end

endmodule

/* design/text_write_ctrl.sv */
`timescale 1ns/1ps

module text_write_ctrl import cpu_io_pkg::*; (
    input  logic                   clk_pipeline,
    input  logic                   rst,
    input  logic                   text_req,
    input  logic [ADDR_W-1:0]      dmem_addr,
    input  logic [3:0]             dmem_byte_w_en,
    input  logic [DATA_W-1:0]      data_from_reg,
    output logic                   text_stall,
    output logic                   text_wen,
    output logic [TEXT_ADDR_W-1:0] text_addr,
    output logic [7:0]             text_char
);

    logic [TEXT_CNT_W-1:0] cnt;
    logic [1:0]            offset;

    // cycle counter, saturates at the end of the stall window
    always_ff @(posedge clk_pipeline) begin
        if (!rst || !text_req) begin
            cnt      <= '0;
            text_wen <= 1'b0;
        end else begin
            if (cnt < TEXT_CNT_W'(TEXT_STALL_CYCLES)) begin
                cnt <= cnt + 1'b1;
            end
            // address and char are stable one cycle before wen
            text_wen <= (cnt < TEXT_CNT_W'(TEXT_WEN_CYCLES));
        end
    end

    // stall starts in the request cycle itself
    assign text_stall = text_req && (cnt < TEXT_CNT_W'(TEXT_STALL_CYCLES));

    // byte lane picks offset and char
    always_comb begin
        case (dmem_byte_w_en)
            4'b1000: begin
                offset    = 2'd0;
                text_char = data_from_reg[7:0];
            end
            4'b0100: begin
                offset    = 2'd1;
                text_char = data_from_reg[15:8];
            end
            4'b0010: begin
                offset    = 2'd2;
                text_char = data_from_reg[23:16];
            end
            default: begin
                offset    = 2'd3;
                text_char = data_from_reg[31:24];
            end
        endcase
    end

    assign text_addr = {dmem_addr[TEXT_ADDR_W-3:0], offset};

    wen_inside_req: assert property (@(posedge clk_pipeline) disable iff (!rst)
        text_wen |-> text_req);

endmodule

/* design/bus_decoder.sv */
`timescale 1ns/1ps

module bus_decoder import cpu_io_pkg::*; (
    input  logic                   clk_pipeline,
    input  logic                   rst,
    input  logic [ADDR_W-1:0]      instr_addr,
    input  logic [ADDR_W-1:0]      dmem_addr,
    input  logic                   dmem_read,
    input  logic                   dmem_write,
    input  logic [DATA_W-1:0]      data_from_reg,
    input  logic [3:0]             dmem_byte_w_en,
    input  logic                   kb_ready,
    input  logic [7:0]             head_code,
    output logic                   kb_pop,
    output logic [DATA_W-1:0]      instr_data_out,
    output logic [DATA_W-1:0]      dmem_data_out,
    output logic                   mem_stall,
    output logic [TEXT_ADDR_W-1:0] text_addr,
    output logic [7:0]             text_char,
    output logic                   text_wen
);

    region_e           dmem_region;
    logic              loader_sel;
    logic              kb_read;
    logic              text_req;
    logic              text_stall;
    logic              instr_loader_q;
    logic [3:0]        data_wen;
    logic [DATA_W-1:0] data_rdata;
    logic [DATA_W-1:0] instr_rdata;

    ////////////////////
    // region decode

    assign dmem_region = region_e'(dmem_addr[REGION_HI:REGION_LO]);
    assign loader_sel  = (dmem_region == REGION_LOADER);
    assign kb_read     = dmem_read && (dmem_region == REGION_KBD);
    assign text_req    = dmem_write && (dmem_region == REGION_TEXT);

    // head leaves the queue in the cycle it is returned
    assign kb_pop = kb_read;

    // cpu enable bit k lands on big-endian lane 3-k
    always_comb begin
        data_wen = 4'b0000;
        if (loader_sel && dmem_write) begin
            case (dmem_byte_w_en)
                4'b0001: data_wen = 4'b1000;
                4'b0010: data_wen = 4'b0100;
                4'b0100: data_wen = 4'b0010;
                4'b1000: data_wen = 4'b0001;
                4'b0011: data_wen = 4'b1100;
                4'b1100: data_wen = 4'b0011;
                default: data_wen = 4'b1111;
            endcase
        end
    end

    ////////////////////
    // read data

    always_comb begin
        case (dmem_region)
            REGION_LOADER: dmem_data_out = data_rdata;
            REGION_KBD:    dmem_data_out = {{(DATA_W - 8){1'b0}}, head_code};
            default:       dmem_data_out = '0;
        endcase
    end

    // fetch region lines up with the ram read latency
    always_ff @(posedge clk_pipeline) begin
        if (!rst) begin
            instr_loader_q <= 1'b0;
        end else begin
            instr_loader_q <= (instr_addr[REGION_HI:REGION_LO] == REGION_LOADER);
        end
    end

    assign instr_data_out = instr_loader_q ? instr_rdata : '0;

    // text window, or keyboard read with nothing queued
    assign mem_stall = text_stall | (kb_read & ~kb_ready);

    loader_mem u_loader_mem (
        .clk_pipeline ( clk_pipeline                     ),
        .data_addr    ( dmem_addr[LOADER_ADDR_W-1:0]     ),
        .instr_addr   ( instr_addr[LOADER_ADDR_W-1:0]    ),
        .data_wen     ( data_wen                         ),
        .wdata        ( data_from_reg                    ),
        .data_rdata   ( data_rdata                       ),
        .instr_rdata  ( instr_rdata                      )
    );

    text_write_ctrl u_text_write_ctrl (
        .clk_pipeline   ( clk_pipeline   ),
        .rst            ( rst            ),
        .text_req       ( text_req       ),
        .dmem_addr      ( dmem_addr      ),
        .dmem_byte_w_en ( dmem_byte_w_en ),
        .data_from_reg  ( data_from_reg  ),
        .text_stall     ( text_stall     ),
        .text_wen       ( text_wen       ),
        .text_addr      ( text_addr      ),
        .text_char      ( text_char      )
    );

endmodule

/* design/cpu_io_top.sv */
`timescale 1ns/1ps

module cpu_io_top import cpu_io_pkg::*; (
    input  logic                   clk_pipeline,
    input  logic                   rst,
    input  logic                   ps2_clk,
    input  logic                   ps2_data,
    input  logic [ADDR_W-1:0]      instr_addr,
    input  logic [ADDR_W-1:0]      dmem_addr,
    input  logic                   dmem_read,
    input  logic                   dmem_write,
    input  logic [DATA_W-1:0]      data_from_reg,
    input  logic [3:0]             dmem_byte_w_en,
    output logic [DATA_W-1:0]      instr_data_out,
    output logic [DATA_W-1:0]      dmem_data_out,
    output logic                   mem_stall,
    output logic                   kb_ready,
    output logic                   kb_overflow,
    output logic                   text_wen,
    output logic [TEXT_ADDR_W-1:0] text_addr,
    output logic [7:0]             text_char
);

    // receiver to queue
    logic       code_valid;
    logic [7:0] code;
    // queue to decoder
    logic       kb_pop;
    logic [7:0] head_code;

    ps2_receiver u_ps2_receiver (
        .clk_pipeline ( clk_pipeline ),
        .rst          ( rst          ),
        .ps2_clk      ( ps2_clk      ),
        .ps2_data     ( ps2_data     ),
        .code_valid   ( code_valid   ),
        .code         ( code         )
    );

    scancode_fifo u_scancode_fifo (
        .clk_pipeline ( clk_pipeline ),
        .rst          ( rst          ),
        .code_valid   ( code_valid   ),
        .code         ( code         ),
        .kb_pop       ( kb_pop       ),
        .kb_ready     ( kb_ready     ),
        .kb_overflow  ( kb_overflow  ),
        .head_code    ( head_code    )
    );

    bus_decoder u_bus_decoder (
        .clk_pipeline   ( clk_pipeline   ),
        .rst            ( rst            ),
        .instr_addr     ( instr_addr     ),
        .dmem_addr      ( dmem_addr      ),
        .dmem_read      ( dmem_read      ),
        .dmem_write     ( dmem_write     ),
        .data_from_reg  ( data_from_reg  ),
        .dmem_byte_w_en ( dmem_byte_w_en ),
        .kb_ready       ( kb_ready       ),
        .head_code      ( head_code      ),
        .kb_pop         ( kb_pop         ),
        .instr_data_out ( instr_data_out ),
        .dmem_data_out  ( dmem_data_out  ),
        .mem_stall      ( mem_stall      ),
        .text_addr      ( text_addr      ),
        .text_char      ( text_char      ),
        .text_wen       ( text_wen       )
    );

endmodule

/* verification/tb_cpu_io.sv */
`timescale 1ns/1ps

module tb_cpu_io import cpu_io_pkg::*; ();

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 10;
    localparam int PS2_HALF      = 10;
    localparam int FRAME_GAP     = 20;
    localparam int FRAME_CYCLES  = PS2_FRAME_BITS * 2 * PS2_HALF + FRAME_GAP;
    localparam int NUM_FRAMES    = 14;
    localparam int ACCESS_CYCLES = 300;
    localparam int MARGIN_CYCLES = 1000;
    localparam int WATCHDOG_NS   =
        (RESET_CYCLES + NUM_FRAMES * FRAME_CYCLES + ACCESS_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

    localparam logic [3:0] PARTIAL_EN [7] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                              4'b0011, 4'b1100, 4'b0110};
    localparam logic [3:0] TEXT_EN [4]    = '{4'b1000, 4'b0100, 4'b0010, 4'b0001};
    localparam logic [ADDR_W-1:0] KBD_ADDR = {REGION_KBD, 26'h0};

    logic                   clk_pipeline;
    logic                   rst;
    logic                   ps2_clk;
    logic                   ps2_data;
    logic [ADDR_W-1:0]      instr_addr;
    logic [ADDR_W-1:0]      dmem_addr;
    logic                   dmem_read;
    logic                   dmem_write;
    logic [DATA_W-1:0]      data_from_reg;
    logic [3:0]             dmem_byte_w_en;
    logic [DATA_W-1:0]      instr_data_out;
    logic [DATA_W-1:0]      dmem_data_out;
    logic                   mem_stall;
    logic                   kb_ready;
    logic                   kb_overflow;
    logic                   text_wen;
    logic [TEXT_ADDR_W-1:0] text_addr;
    logic [7:0]             text_char;

    // scoreboard of keycodes still in the queue
    logic [7:0]        expected_codes [$];
    logic [DATA_W-1:0] model_word;
    logic [9:0]        word_idx;
    logic [7:0]        stall_code;
    int unsigned       seed_value;

    cpu_io_top DUT (
        .clk_pipeline   ( clk_pipeline   ),
        .rst            ( rst            ),
        .ps2_clk        ( ps2_clk        ),
        .ps2_data       ( ps2_data       ),
        .instr_addr     ( instr_addr     ),
        .dmem_addr      ( dmem_addr      ),
        .dmem_read      ( dmem_read      ),
        .dmem_write     ( dmem_write     ),
        .data_from_reg  ( data_from_reg  ),
        .dmem_byte_w_en ( dmem_byte_w_en ),
        .instr_data_out ( instr_data_out ),
        .dmem_data_out  ( dmem_data_out  ),
        .mem_stall      ( mem_stall      ),
        .kb_ready       ( kb_ready       ),
        .kb_overflow    ( kb_overflow    ),
        .text_wen       ( text_wen       ),
        .text_addr      ( text_addr      ),
        .text_char      ( text_char      )
    );

    always #(CLK_PERIOD / 2) clk_pipeline = ~clk_pipeline;

    ////////////////////
    // helpers

    task automatic stop_with_failure();
        $display("TESTS FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("MISMATCH time=%0t signal=%s expected=0x%h actual=0x%h",
                     $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    // inputs change 2 ns after the rising edge
    task automatic tick();
        @(posedge clk_pipeline);
        #2;
    endtask

    // cpu bit k goes to lane 3-k for the listed patterns, all lanes otherwise
    function automatic logic [3:0] big_endian_lanes(input logic [3:0] en);
        logic [3:0] lanes;
        lanes = 4'hF;
        if (en inside {4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100}) begin
            lanes = {en[0], en[1], en[2], en[3]};
        end
        return lanes;
    endfunction

    task automatic loader_write(input logic [9:0] idx, input logic [3:0] en,
                                input logic [31:0] data);
        logic [3:0] lanes;
        lanes = big_endian_lanes(en);
        for (int j = 0; j < 4; j++) begin
            if (lanes[j]) begin
                model_word[8*j +: 8] = data[8*j +: 8];
            end
        end
        dmem_addr      = {REGION_LOADER, 16'h0, idx};
        data_from_reg  = data;
        dmem_byte_w_en = en;
        dmem_write     = 1'b1;
        tick();
        dmem_write = 1'b0;
    endtask

    // registered read, word shows up one cycle later
    task automatic loader_readback();
        tick();
        @(negedge clk_pipeline);
        check_equal("dmem_data_out", model_word, dmem_data_out);
        tick();
    endtask

    task automatic text_write(input logic [3:0] en);
        logic [12:0] low;
        logic [31:0] data;
        logic [1:0]  offset;
        logic [7:0]  char_exp;
        low          = 13'($urandom());
        data         = $urandom();
        offset       = (en == 4'b1000) ? 2'd0 : (en == 4'b0100) ? 2'd1 :
                       (en == 4'b0010) ? 2'd2 : 2'd3;
        char_exp     = 8'(data >> (8 * offset));
        dmem_addr      = {REGION_TEXT, 13'h0, low};
        data_from_reg  = data;
        dmem_byte_w_en = en;
        dmem_write     = 1'b1;
        // cycle 0 is the request cycle, the request is held while stalled
        for (int n = 0; n <= TEXT_STALL_CYCLES; n++) begin
            @(negedge clk_pipeline);
            check_equal("mem_stall", 32'(n < TEXT_STALL_CYCLES), 32'(mem_stall));
            check_equal("text_wen", 32'(n >= 1 && n <= TEXT_WEN_CYCLES), 32'(text_wen));
            if (text_wen) begin
                check_equal("text_addr", 32'({low, offset}), 32'(text_addr));
                check_equal("text_char", 32'(char_exp), 32'(text_char));
            end
            tick();
        end
        dmem_write = 1'b0;
        @(negedge clk_pipeline);
        check_equal("text_wen", 32'h0, 32'(text_wen));
        tick();
    endtask

    // start, 8 data bits lsb first, odd parity, stop
    task automatic send_frame(input logic [7:0] data, input logic good_parity);
        logic [PS2_FRAME_BITS-1:0] bits;
        bits = {1'b1, (~^data) ^ ~good_parity, data, 1'b0};
        for (int i = 0; i < PS2_FRAME_BITS; i++) begin
            ps2_data = bits[i];
            repeat (PS2_HALF) tick();
            ps2_clk = 1'b0;
            repeat (PS2_HALF) tick();
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
        repeat (FRAME_GAP) tick();
    endtask

    task automatic send_good_frame();
        logic [7:0] data;
        data = 8'($urandom());
        expected_codes.push_back(data);
        send_frame(data, 1'b1);
    endtask

    // holds the read until the stall clears, then compares with the scoreboard
    task automatic keyboard_read();
        logic [7:0] exp_code;
        dmem_addr = KBD_ADDR;
        dmem_read = 1'b1;
        @(negedge clk_pipeline);
        while (mem_stall) begin
            tick();
            @(negedge clk_pipeline);
        end
        assert (expected_codes.size() > 0) else begin
            $display("ERROR time=%0t keyboard read returned with no code expected", $time);
            stop_with_failure();
        end
        exp_code = expected_codes.pop_front();
        check_equal("dmem_data_out", {24'h0, exp_code}, dmem_data_out);
        tick();
        dmem_read = 1'b0;
    endtask

    ////////////////////
    // checks on every edge

    wen_in_stall: assert property (@(posedge clk_pipeline) disable iff (!rst)
        text_wen |-> mem_stall)
    else begin
        $display("ERROR time=%0t text_wen high outside the stall window", $time);
        stop_with_failure();
    end

    overflow_sticky: assert property (@(posedge clk_pipeline) disable iff (!rst)
        kb_overflow |=> kb_overflow)
    else begin
        $display("ERROR time=%0t kb_overflow cleared without reset", $time);
        stop_with_failure();
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR timeout, the tests did not finish in time");
        stop_with_failure();
    end

    ////////////////////
    // main sequence

    initial begin
        seed_value     = $urandom(99547);
        clk_pipeline   = 1'b0;
        rst            = 1'b0;
        ps2_clk        = 1'b1;
        ps2_data       = 1'b1;
        instr_addr     = '0;
        dmem_addr      = '0;
        dmem_read      = 1'b0;
        dmem_write     = 1'b0;
        data_from_reg  = '0;
        dmem_byte_w_en = '0;
        model_word     = '0;
        repeat (RESET_CYCLES) @(posedge clk_pipeline);
        #2;
        rst = 1'b1;
        @(negedge clk_pipeline);
        check_equal("text_wen", 32'h0, 32'(text_wen));
        check_equal("mem_stall", 32'h0, 32'(mem_stall));
        check_equal("kb_ready", 32'h0, 32'(kb_ready));
        check_equal("kb_overflow", 32'h0, 32'(kb_overflow));
        check_equal("code_valid", 32'h0, 32'(DUT.code_valid));
        tick();

        // loader full word, then every byte-enable pattern
        word_idx = 10'($urandom());
        loader_write(word_idx, 4'b1111, $urandom());
        loader_readback();
        for (int i = 0; i < 7; i++) begin
            loader_write(word_idx, PARTIAL_EN[i], $urandom());
            loader_readback();
        end
        instr_addr = {REGION_LOADER, 16'h0, word_idx};
        tick();
        @(negedge clk_pipeline);
        check_equal("instr_data_out", model_word, instr_data_out);
        tick();

        // unmapped data read and fetch
        dmem_addr  = {4'h3, 16'h0, word_idx};
        dmem_read  = 1'b1;
        instr_addr = {4'h5, 16'h0, word_idx};
        tick();
        @(negedge clk_pipeline);
        check_equal("dmem_data_out", 32'h0, dmem_data_out);
        check_equal("mem_stall", 32'h0, 32'(mem_stall));
        check_equal("instr_data_out", 32'h0, instr_data_out);
        tick();
        dmem_read = 1'b0;

        for (int i = 0; i < 4; i++) begin
            text_write(TEXT_EN[i]);
        end

        // keyboard codes come back in order
        repeat (3) send_good_frame();
        @(negedge clk_pipeline);
        check_equal("kb_ready", 32'h1, 32'(kb_ready));
        tick();
        repeat (3) keyboard_read();
        @(negedge clk_pipeline);
        check_equal("kb_ready", 32'h0, 32'(kb_ready));
        tick();

        // empty read stalls through a bad frame until a good one lands
        stall_code = 8'($urandom());
        fork
            keyboard_read();
            begin
                send_frame(8'($urandom()), 1'b0);
                @(negedge clk_pipeline);
                check_equal("mem_stall", 32'h1, 32'(mem_stall));
                check_equal("kb_ready", 32'h0, 32'(kb_ready));
                tick();
                expected_codes.push_back(stall_code);
                send_frame(stall_code, 1'b1);
            end
        join

        // ninth frame hits a full queue
        repeat (KBD_FIFO_DEPTH) send_good_frame();
        @(negedge clk_pipeline);
        check_equal("kb_overflow", 32'h0, 32'(kb_overflow));
        tick();
        send_frame(8'($urandom()), 1'b1);
        @(negedge clk_pipeline);
        check_equal("kb_overflow", 32'h1, 32'(kb_overflow));
        tick();
        repeat (KBD_FIFO_DEPTH) keyboard_read();
        @(negedge clk_pipeline);
        check_equal("kb_ready", 32'h0, 32'(kb_ready));

        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* sim.f */
design/cpu_io_pkg.sv
design/ps2_receiver.sv
design/scancode_fifo.sv
design/loader_mem.sv
design/text_write_ctrl.sv
design/bus_decoder.sv
design/cpu_io_top.sv
verification/tb_cpu_io.sv

/* run_sim.sh */
#!/bin/sh
# build and run the cpu_io testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_cpu_io -f sim.f -o Vtb_cpu_io

./obj_dir/Vtb_cpu_io | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi
# a run that stopped early has no pass line
grep -q "TESTS PASSED" sim.log
